//--- hdl/gpif_pkg.sv
// Line formats follow the 36-bit FIFO convention; occ is only meaningful on an eof line
package gpif_pkg;

   // Host-side line, one 16-bit word plus framing
   typedef struct packed {
      logic        eof;
      logic        sof;
      logic [15:0] data;
   } gpif_line_t;

   // First host word sits in data[15:0]
   typedef struct packed {
      logic [1:0]  occ;
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } line36_t;

   localparam logic [1:0] OCC_FULL = 2'b00;   // Both halves valid
   localparam logic [1:0] OCC_LOW  = 2'b10;   // Low half only, odd-length packet

   localparam int GPIF_DEPTH_LOG2  = 4;
   localparam int SHORT_DEPTH_LOG2 = 3;
   localparam int TX_SPACE_MARGIN  = 2;       // Absorbs the one-cycle lag of have_space

   // Top nibble of the first line, i.e. of the second host word
   localparam logic [3:0] CTRL_MATCH = 4'h1;

endpackage

//--- hdl/fifo_short.sv
// Single clock; DEPTH_LOG2 must be at least 1, level_o counts stored entries including a full FIFO
`timescale 1ns/1ps

module fifo_short #(
   parameter type payload_t  = logic [35:0],
   parameter int  DEPTH_LOG2 = 3
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  payload_t            data_i,
   input  logic                src_rdy_i,
   output logic                dst_rdy_o,
   output payload_t            data_o,
   output logic                src_rdy_o,
   input  logic                dst_rdy_i,
   output logic [DEPTH_LOG2:0] level_o
);

   payload_t              mem [2**DEPTH_LOG2];
   logic [DEPTH_LOG2-1:0] wr_ptr_q;
   logic [DEPTH_LOG2-1:0] rd_ptr_q;
   logic [DEPTH_LOG2:0]   count_q;
   logic                  push;
   logic                  pop;

   // MSB of the count is set only when full
   assign dst_rdy_o = ~count_q[DEPTH_LOG2];
   assign src_rdy_o = (count_q != '0);
   assign data_o    = mem[rd_ptr_q];
   assign level_o   = count_q;

   assign push = src_rdy_i & dst_rdy_o;
   assign pop  = src_rdy_o & dst_rdy_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;     // Idle or push and pop together
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (push)
         mem[wr_ptr_q] <= data_i;
   end

endmodule

//--- hdl/gpif_wr.sv
// Host must hold WR low while have_space is low; a word written with EOP closes the packet
`timescale 1ns/1ps

module gpif_wr (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic [15:0]          gpif_data_i,
   input  logic                 gpif_wr_i,
   input  logic                 gpif_eop_i,
   output logic                 have_space_o,
   output gpif_pkg::gpif_line_t data_o,
   output logic                 src_rdy_o,
   input  logic                 dst_rdy_i
);

   import gpif_pkg::*;

   gpif_line_t               wr_line;
   logic                     buf_dst_rdy;
   logic [GPIF_DEPTH_LOG2:0] buf_level;
   logic                     first_q;       // Next word opens a packet

   assign wr_line.data = gpif_data_i;
   assign wr_line.sof  = first_q;
   assign wr_line.eof  = gpif_eop_i;

   fifo_short #(
      .payload_t  (gpif_line_t),
      .DEPTH_LOG2 (GPIF_DEPTH_LOG2)
   ) u_wr_buf (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .data_i    (wr_line),
      .src_rdy_i (gpif_wr_i),
      .dst_rdy_o (buf_dst_rdy),
      .data_o    (data_o),
      .src_rdy_o (src_rdy_o),
      .dst_rdy_i (dst_rdy_i),
      .level_o   (buf_level)
   );

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         first_q      <= 1'b1;
         have_space_o <= 1'b1;
      end else begin
         if (gpif_wr_i && buf_dst_rdy)
            first_q <= gpif_eop_i;
         // Space flag lags the level by one cycle
         have_space_o <= (int'(buf_level) + TX_SPACE_MARGIN) <= (2 ** GPIF_DEPTH_LOG2);
      end
   end

endmodule

//--- hdl/fifo18_to_fifo36.sv
// Little-endian packing, first word in the low half; high-half sof is ignored
`timescale 1ns/1ps

module fifo18_to_fifo36 (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  gpif_pkg::gpif_line_t data_i,
   input  logic                 src_rdy_i,
   output logic                 dst_rdy_o,
   output gpif_pkg::line36_t    data_o,
   output logic                 src_rdy_o,
   input  logic                 dst_rdy_i
);

   import gpif_pkg::*;

   logic       half_q;          // Waiting for the high half
   gpif_line_t low_q;
   logic       in_fire;
   logic       out_fire;

   // Takes input only while the output line is empty
   assign dst_rdy_o = ~src_rdy_o;
   assign in_fire   = src_rdy_i & dst_rdy_o;
   assign out_fire  = src_rdy_o & dst_rdy_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         half_q    <= 1'b0;
         src_rdy_o <= 1'b0;
      end else begin
         if (out_fire)
            src_rdy_o <= 1'b0;
         if (in_fire) begin
            if (!half_q && !data_i.eof) begin
               half_q <= 1'b1;
            end else begin
               half_q    <= 1'b0;   // Line closes here
               src_rdy_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_fire && !half_q) begin
         low_q       <= data_i;
         data_o.occ  <= OCC_LOW;    // Stands if eof lands in the low half
         data_o.eof  <= data_i.eof;
         data_o.sof  <= data_i.sof;
         data_o.data <= {16'h0000, data_i.data};
      end else if (in_fire) begin
         data_o.occ  <= OCC_FULL;
         data_o.eof  <= data_i.eof;
         data_o.sof  <= low_q.sof;
         data_o.data <= {data_i.data, low_q.data};
      end
   end

endmodule

//--- hdl/fifo36_demux.sv
// Route is picked from the sof line in an idle cycle, so each packet costs one extra cycle
`timescale 1ns/1ps

module fifo36_demux (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  gpif_pkg::line36_t data_i,
   input  logic              src_rdy_i,
   output logic              dst_rdy_o,
   output gpif_pkg::line36_t ctrl_data_o,
   output logic              ctrl_src_rdy_o,
   input  logic              ctrl_dst_rdy_i,
   output gpif_pkg::line36_t data_o,
   output logic              src_rdy_o,
   input  logic              dst_rdy_i
);

   import gpif_pkg::*;

   typedef enum logic [1:0] {DMX_IDLE, DMX_CTRL, DMX_DATA} dmx_state_e;

   dmx_state_e state_q;
   logic       in_fire;

   assign ctrl_data_o    = data_i;
   assign data_o         = data_i;
   assign ctrl_src_rdy_o = src_rdy_i & (state_q == DMX_CTRL);
   assign src_rdy_o      = src_rdy_i & (state_q == DMX_DATA);
   assign dst_rdy_o      = ((state_q == DMX_CTRL) & ctrl_dst_rdy_i) |
                           ((state_q == DMX_DATA) & dst_rdy_i);
   assign in_fire        = src_rdy_i & dst_rdy_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= DMX_IDLE;
      end else begin
         case (state_q)
            DMX_IDLE: begin
               // Header match on the first line only
               if (src_rdy_i) begin
                  if (data_i.sof && (data_i.data[31:28] == CTRL_MATCH))
                     state_q <= DMX_CTRL;
                  else
                     state_q <= DMX_DATA;
               end
            end
            default: begin
               if (in_fire && data_i.eof)
                  state_q <= DMX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- hdl/fifo36_mux.sv
// Prio input wins a tie in idle; a grant is never broken before the eof line
`timescale 1ns/1ps

module fifo36_mux (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  gpif_pkg::line36_t prio_data_i,
   input  logic              prio_src_rdy_i,
   output logic              prio_dst_rdy_o,
   input  gpif_pkg::line36_t data_i,
   input  logic              src_rdy_i,
   output logic              dst_rdy_o,
   output gpif_pkg::line36_t data_o,
   output logic              src_rdy_o,
   input  logic              dst_rdy_i
);

   import gpif_pkg::*;

   typedef enum logic [1:0] {MUX_IDLE, MUX_PRIO, MUX_DATA} mux_state_e;

   mux_state_e state_q;
   logic       sel_prio;        // Prio input drives the output
   logic       out_fire;

   always_comb begin
      case (state_q)
         MUX_PRIO: sel_prio = 1'b1;
         MUX_DATA: sel_prio = 1'b0;
         default:  sel_prio = prio_src_rdy_i;
      endcase
   end

   assign data_o         = sel_prio ? prio_data_i : data_i;
   assign src_rdy_o      = sel_prio ? prio_src_rdy_i : src_rdy_i;
   assign prio_dst_rdy_o = dst_rdy_i & (state_q != MUX_DATA);
   assign dst_rdy_o      = dst_rdy_i & ~sel_prio;
   assign out_fire       = src_rdy_o & dst_rdy_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= MUX_IDLE;
      end else begin
         case (state_q)
            MUX_IDLE: begin
               // Single-line packets never leave idle
               if (out_fire && !data_o.eof)
                  state_q <= sel_prio ? MUX_PRIO : MUX_DATA;
            end
            default: begin
               if (out_fire && data_o.eof)
                  state_q <= MUX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- hdl/fifo36_to_fifo18.sv
// Low half goes out first; occ is honoured only on the eof line
`timescale 1ns/1ps

module fifo36_to_fifo18 (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  gpif_pkg::line36_t    data_i,
   input  logic                 src_rdy_i,
   output logic                 dst_rdy_o,
   output gpif_pkg::gpif_line_t data_o,
   output logic                 src_rdy_o,
   input  logic                 dst_rdy_i
);

   import gpif_pkg::*;

   logic half_q;                // High half is next
   logic last;
   logic out_fire;

   // Last valid half of the current line
   assign last = half_q | (data_i.eof & (data_i.occ == OCC_LOW));

   assign data_o.data = half_q ? data_i.data[31:16] : data_i.data[15:0];
   assign data_o.sof  = data_i.sof & ~half_q;
   assign data_o.eof  = data_i.eof & last;

   assign src_rdy_o = src_rdy_i;
   assign dst_rdy_o = dst_rdy_i & last;   // Pop after the last half
   assign out_fire  = src_rdy_i & dst_rdy_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i)
         half_q <= 1'b0;
      else if (out_fire)
         half_q <= ~last;
   end

endmodule

//--- hdl/gpif_rd.sv
// A packet must fit in the read buffer, since have_pkt rises only once its eof is stored
`timescale 1ns/1ps

module gpif_rd (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  gpif_pkg::gpif_line_t data_i,
   input  logic                 src_rdy_i,
   output logic                 dst_rdy_o,
   input  logic                 gpif_rd_i,
   output logic [15:0]          gpif_data_o,
   output logic                 have_pkt_o
);

   import gpif_pkg::*;

   gpif_line_t               buf_data;
   logic                     buf_src_rdy;
   logic                     buf_pop;
   logic                     pkt_in;
   logic                     pkt_out;
   logic [GPIF_DEPTH_LOG2:0] pkt_cnt_q;     // Complete packets not yet started

   fifo_short #(
      .payload_t  (gpif_line_t),
      .DEPTH_LOG2 (GPIF_DEPTH_LOG2)
   ) u_rd_buf (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .data_i    (data_i),
      .src_rdy_i (src_rdy_i),
      .dst_rdy_o (dst_rdy_o),
      .data_o    (buf_data),
      .src_rdy_o (buf_src_rdy),
      .dst_rdy_i (gpif_rd_i),
      .level_o   ()
   );

   assign buf_pop    = gpif_rd_i & buf_src_rdy;
   assign pkt_in     = src_rdy_i & dst_rdy_o & data_i.eof;
   assign pkt_out    = buf_pop & buf_data.sof;
   assign have_pkt_o = (pkt_cnt_q != '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pkt_cnt_q <= '0;
      end else begin
         case ({pkt_in, pkt_out})
            2'b10:   pkt_cnt_q <= pkt_cnt_q + 1'b1;
            2'b01:   pkt_cnt_q <= pkt_cnt_q - 1'b1;
            default: pkt_cnt_q <= pkt_cnt_q;
         endcase
      end
   end

   // Read data register, host samples it the cycle after RD
   always_ff @(posedge clk_i) begin
      if (buf_pop)
         gpif_data_o <= buf_data.data;
   end

endmodule

//--- hdl/gpif.sv
// One clock for host and FIFO sides; control and response packets enter and leave as plain ports
`timescale 1ns/1ps

module gpif (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   inout  wire  [15:0]                         gpif_d_io,
   input  logic [3:0]                          gpif_ctl_i,
   output logic [1:0]                          gpif_rdy_o,
   output logic [$bits(gpif_pkg::line36_t)-1:0] tx_data_o,
   output logic                                tx_src_rdy_o,
   input  logic                                tx_dst_rdy_i,
   output logic [$bits(gpif_pkg::line36_t)-1:0] ctrl_data_o,
   output logic                                ctrl_src_rdy_o,
   input  logic                                ctrl_dst_rdy_i,
   input  logic [$bits(gpif_pkg::line36_t)-1:0] rx_data_i,
   input  logic                                rx_src_rdy_i,
   output logic                                rx_dst_rdy_o,
   input  logic [$bits(gpif_pkg::line36_t)-1:0] resp_data_i,
   input  logic                                resp_src_rdy_i,
   output logic                                resp_dst_rdy_o
);

   import gpif_pkg::*;

   ////////////////////
   // Host bus
   logic        wr;
   logic        rd;
   logic        oe;
   logic        eop;
   logic        have_space;
   logic        have_pkt;
   logic [15:0] gpif_rd_data;

   assign wr  = gpif_ctl_i[0];
   assign rd  = gpif_ctl_i[1];
   assign oe  = gpif_ctl_i[2];
   assign eop = gpif_ctl_i[3];

   assign gpif_d_io  = oe ? gpif_rd_data : 16'bz;   // Host releases the bus under OE
   assign gpif_rdy_o = {have_pkt, have_space};

   ////////////////////
   // Transmit chain
   gpif_line_t tx18_data;
   logic       tx18_src_rdy, tx18_dst_rdy;
   line36_t    tx36_data, tx36b_data;
   logic       tx36_src_rdy, tx36_dst_rdy;
   logic       tx36b_src_rdy, tx36b_dst_rdy;

   gpif_wr u_gpif_wr (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .gpif_data_i (gpif_d_io), .gpif_wr_i (wr), .gpif_eop_i (eop),
      .have_space_o (have_space),
      .data_o (tx18_data), .src_rdy_o (tx18_src_rdy), .dst_rdy_i (tx18_dst_rdy)
   );

   fifo18_to_fifo36 u_f18_to_f36 (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .data_i (tx18_data), .src_rdy_i (tx18_src_rdy), .dst_rdy_o (tx18_dst_rdy),
      .data_o (tx36_data), .src_rdy_o (tx36_src_rdy), .dst_rdy_i (tx36_dst_rdy)
   );

   fifo_short #(.payload_t (line36_t), .DEPTH_LOG2 (SHORT_DEPTH_LOG2)) u_tx_sfifo (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .data_i (tx36_data), .src_rdy_i (tx36_src_rdy), .dst_rdy_o (tx36_dst_rdy),
      .data_o (tx36b_data), .src_rdy_o (tx36b_src_rdy), .dst_rdy_i (tx36b_dst_rdy),
      .level_o ()
   );

   fifo36_demux u_tx_demux (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .data_i (tx36b_data), .src_rdy_i (tx36b_src_rdy), .dst_rdy_o (tx36b_dst_rdy),
      .ctrl_data_o (ctrl_data_o), .ctrl_src_rdy_o (ctrl_src_rdy_o),
      .ctrl_dst_rdy_i (ctrl_dst_rdy_i),
      .data_o (tx_data_o), .src_rdy_o (tx_src_rdy_o), .dst_rdy_i (tx_dst_rdy_i)
   );

   ////////////////////
   // Receive chain, responses first
   line36_t    rx36_data, rx36b_data;
   logic       rx36_src_rdy, rx36_dst_rdy;
   logic       rx36b_src_rdy, rx36b_dst_rdy;
   gpif_line_t rx18_data;
   logic       rx18_src_rdy, rx18_dst_rdy;

   fifo36_mux u_rx_mux (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .prio_data_i (resp_data_i), .prio_src_rdy_i (resp_src_rdy_i),
      .prio_dst_rdy_o (resp_dst_rdy_o),
      .data_i (rx_data_i), .src_rdy_i (rx_src_rdy_i), .dst_rdy_o (rx_dst_rdy_o),
      .data_o (rx36_data), .src_rdy_o (rx36_src_rdy), .dst_rdy_i (rx36_dst_rdy)
   );

   fifo_short #(.payload_t (line36_t), .DEPTH_LOG2 (SHORT_DEPTH_LOG2)) u_rx_sfifo (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .data_i (rx36_data), .src_rdy_i (rx36_src_rdy), .dst_rdy_o (rx36_dst_rdy),
      .data_o (rx36b_data), .src_rdy_o (rx36b_src_rdy), .dst_rdy_i (rx36b_dst_rdy),
      .level_o ()
   );

   fifo36_to_fifo18 u_f36_to_f18 (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .data_i (rx36b_data), .src_rdy_i (rx36b_src_rdy), .dst_rdy_o (rx36b_dst_rdy),
      .data_o (rx18_data), .src_rdy_o (rx18_src_rdy), .dst_rdy_i (rx18_dst_rdy)
   );

   gpif_rd u_gpif_rd (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .data_i (rx18_data), .src_rdy_i (rx18_src_rdy), .dst_rdy_o (rx18_dst_rdy),
      .gpif_rd_i (rd), .gpif_data_o (gpif_rd_data), .have_pkt_o (have_pkt)
   );

endmodule

//--- bench/gpif_checker.sv
// Bound into gpif; wr_level taps the transmit buffer level inside gpif_wr
`timescale 1ns/1ps

module gpif_checker (
   input logic        clk_i,
   input logic        rst_n_i,
   input logic [35:0] tx_data_o,
   input logic        tx_src_rdy_o,
   input logic        tx_dst_rdy_i,
   input logic [35:0] ctrl_data_o,
   input logic        ctrl_src_rdy_o,
   input logic        ctrl_dst_rdy_i,
   input logic        rx_dst_rdy_o,
   input logic [1:0]  gpif_rdy_o,
   input logic [4:0]  wr_level
);

   ////////////////////
   // Stream rules
   tx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_src_rdy_o && !tx_dst_rdy_i |=> $stable(tx_data_o))
      else $error("tx data changed while stalled");

   ctrl_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ctrl_src_rdy_o && !ctrl_dst_rdy_i |=> $stable(ctrl_data_o))
      else $error("ctrl data changed while stalled");

   space_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wr_level == 0 |-> gpif_rdy_o[0])
      else $error("have_space low with an empty transmit buffer");

   rx_ready_after_reset: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> rx_dst_rdy_o)
      else $error("rx_dst_rdy_o low after reset");

endmodule

bind gpif gpif_checker u_checker (
   .clk_i (clk_i), .rst_n_i (rst_n_i),
   .tx_data_o (tx_data_o), .tx_src_rdy_o (tx_src_rdy_o), .tx_dst_rdy_i (tx_dst_rdy_i),
   .ctrl_data_o (ctrl_data_o), .ctrl_src_rdy_o (ctrl_src_rdy_o),
   .ctrl_dst_rdy_i (ctrl_dst_rdy_i),
   .rx_dst_rdy_o (rx_dst_rdy_o), .gpif_rdy_o (gpif_rdy_o),
   .wr_level (u_gpif_wr.buf_level)
);

//--- bench/gpif_tb.sv
// Single clock model of the host bus; the run stops at a cycle limit sized from the test lengths
`timescale 1ns/1ps

module gpif_tb;

   import gpif_pkg::*;

   localparam int TEST_CYCLES = 150;                  // Back-pressure test is the longest
   localparam int MAX_CYCLES  = 5 * TEST_CYCLES + 100;

   logic        clk_i;
   logic        rst_n_i;
   logic [3:0]  ctl;                                  // WR, RD, OE, EOP
   logic [15:0] host_d;
   wire  [15:0] gpif_d;
   logic [1:0]  rdy;
   logic [35:0] tx_data, ctrl_data, rx_data, resp_data;
   logic        tx_src_rdy, tx_dst_rdy, ctrl_src_rdy, ctrl_dst_rdy;
   logic        rx_src_rdy, rx_dst_rdy, resp_src_rdy, resp_dst_rdy;
   logic [31:0] seed;
   int          cycles, checks, errors;
   logic [15:0] words_q[$], want_words[$], resp_words[$], rx_words[$];
   line36_t     exp_lines[$], seen_lines[$], rx_lines[$], resp_lines[$];

   assign gpif_d = ctl[2] ? 16'bz : host_d;          // Host lets go while OE is high

   gpif uut (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .gpif_d_io (gpif_d), .gpif_ctl_i (ctl),
      .gpif_rdy_o (rdy),
      .tx_data_o (tx_data), .tx_src_rdy_o (tx_src_rdy), .tx_dst_rdy_i (tx_dst_rdy),
      .ctrl_data_o (ctrl_data), .ctrl_src_rdy_o (ctrl_src_rdy),
      .ctrl_dst_rdy_i (ctrl_dst_rdy),
      .rx_data_i (rx_data), .rx_src_rdy_i (rx_src_rdy), .rx_dst_rdy_o (rx_dst_rdy),
      .resp_data_i (resp_data), .resp_src_rdy_i (resp_src_rdy),
      .resp_dst_rdy_o (resp_dst_rdy)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   function automatic logic [15:0] lcg_word();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed[31:16];
   endfunction

   ////////////////////
   // Compare tasks
   task automatic check_line(string what, line36_t exp, line36_t got);
      logic bad;
      checks++;
      bad = (exp.sof !== got.sof) || (exp.eof !== got.eof) || (exp.occ !== got.occ);
      if (exp.occ == OCC_LOW && exp.eof)
         bad = bad || (exp.data[15:0] !== got.data[15:0]);   // High half unused
      else
         bad = bad || (exp.data !== got.data);
      if (bad) begin
         errors++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(string what, logic [15:0] exp_w, logic [15:0] got_w,
                             bit pkt_known, logic exp_pkt, logic got_pkt);
      checks++;
      if (got_w !== exp_w || (pkt_known && got_pkt !== exp_pkt)) begin
         errors++;
         $display("ERR %0t: %s got %h/%b expected %h/%b", $time, what, got_w, got_pkt,
                  exp_w, exp_pkt);
      end
   endtask

   task automatic check_flag(string what, logic exp, logic got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   ////////////////////
   // Stimulus helpers
   task automatic make_words(int n, bit ctrl);
      words_q.delete();
      for (int i = 0; i < n; i++)
         words_q.push_back(lcg_word());
      if (n > 1 && ctrl)
         words_q[1][15:12] = CTRL_MATCH;
      else if (n > 1 && words_q[1][15:12] == CTRL_MATCH)
         words_q[1][15:12] = CTRL_MATCH ^ 4'h8;       // Keep data packets off the ctrl port
   endtask

   // Little-endian pairs, odd tail in the low half
   task automatic pack_words();
      line36_t l;
      exp_lines.delete();
      for (int i = 0; i < words_q.size(); i += 2) begin
         l.sof = (i == 0);
         l.eof = (i + 2 >= words_q.size());
         l.occ = (i + 1 < words_q.size()) ? OCC_FULL : OCC_LOW;
         l.data = {(i + 1 < words_q.size()) ? words_q[i+1] : 16'h0000, words_q[i]};
         exp_lines.push_back(l);
      end
   endtask

   task automatic host_write(logic [15:0] w, logic eop);
      while (!rdy[0])
         @(negedge clk_i);
      host_d = w;
      ctl    = {eop, 3'b001};
      @(negedge clk_i);
      ctl    = 4'b0000;
   endtask

   task automatic collect_packet(bit from_ctrl);
      line36_t l;
      logic    take;
      seen_lines.delete();
      do begin
         @(negedge clk_i);
         tx_dst_rdy = 1'b1;
         if (from_ctrl) begin
            ctrl_dst_rdy = ~ctrl_dst_rdy;             // Stall the ctrl port every other cycle
            check_flag("tx src_rdy", 1'b0, tx_src_rdy);
            l    = line36_t'(ctrl_data);
            take = ctrl_src_rdy & ctrl_dst_rdy;
         end else begin
            check_flag("ctrl src_rdy", 1'b0, ctrl_src_rdy);
            l    = line36_t'(tx_data);
            take = tx_src_rdy;
         end
         if (take)
            seen_lines.push_back(l);
      end while (seen_lines.size() == 0 || !seen_lines[$].eof);
      ctrl_dst_rdy = 1'b1;
   endtask

   task automatic compare_lines(string what);
      if (seen_lines.size() != exp_lines.size()) begin
         errors++;
         $display("%s packet had %0d lines instead of %0d", what, seen_lines.size(),
                  exp_lines.size());
      end
      for (int i = 0; i < seen_lines.size() && i < exp_lines.size(); i++)
         check_line(what, exp_lines[i], seen_lines[i]);
   endtask

   task automatic send_lines(bit to_resp);
      int i;
      i = 0;
      while (i < (to_resp ? resp_lines.size() : rx_lines.size())) begin
         if (to_resp) begin
            resp_data = resp_lines[i];
            resp_src_rdy = 1'b1;
         end else begin
            rx_data = rx_lines[i];
            rx_src_rdy = 1'b1;
         end
         #1;                                          // Settled ready seen by the next edge
         if (to_resp ? resp_dst_rdy : rx_dst_rdy)
            i++;
         @(negedge clk_i);
      end
      if (to_resp)
         resp_src_rdy = 1'b0;
      else
         rx_src_rdy = 1'b0;
   endtask

   task automatic read_packet(bit pend_end);
      int n;
      n = want_words.size();
      while (!rdy[1])
         @(negedge clk_i);
      for (int i = 0; i < n; i++) begin
         ctl = 4'b0110;                               // RD with OE
         @(negedge clk_i);
         check_word("read word", want_words[i], gpif_d, (i == n - 1) || !pend_end,
                    pend_end, rdy[1]);
      end
      ctl = 4'b0000;
   endtask

   ////////////////////
   // Directed tests
   task automatic test_reset();
      check_flag("have_space", 1'b1, rdy[0]);
      check_flag("have_pkt", 1'b0, rdy[1]);
      check_flag("tx src_rdy", 1'b0, tx_src_rdy);
      check_flag("ctrl src_rdy", 1'b0, ctrl_src_rdy);
      check_flag("rx dst_rdy", 1'b1, rx_dst_rdy);
      check_flag("resp dst_rdy", 1'b1, resp_dst_rdy);
      $display("test_reset done, errors %0d", errors);
   endtask

   task automatic send_and_check(int n, bit ctrl, string what);
      make_words(n, ctrl);
      pack_words();
      fork
         for (int i = 0; i < n; i++)
            host_write(words_q[i], i == n - 1);
         collect_packet(ctrl);
      join
      compare_lines(what);
   endtask

   task automatic test_even_packet();
      send_and_check(8, 1'b0, "tx line");
      $display("test_even_packet done, errors %0d", errors);
   endtask

   task automatic test_odd_and_ctrl();
      send_and_check(5, 1'b0, "tx odd line");
      send_and_check(6, 1'b1, "ctrl line");
      $display("test_odd_and_ctrl done, errors %0d", errors);
   endtask

   task automatic test_back_pressure();
      tx_dst_rdy = 1'b0;
      words_q.delete();
      while (rdy[0] && words_q.size() < 64) begin
         words_q.push_back(lcg_word());
         if (words_q.size() == 2 && words_q[1][15:12] == CTRL_MATCH)
            words_q[1][15:12] = CTRL_MATCH ^ 4'h8;
         host_write(words_q[$], 1'b0);
      end
      check_flag("have_space while stalled", 1'b0, rdy[0]);
      words_q.push_back(lcg_word());
      pack_words();
      fork
         collect_packet(1'b0);                        // Releases tx_dst_rdy
         host_write(words_q[$], 1'b1);
      join
      compare_lines("stalled tx line");
      $display("test_back_pressure done, %0d words, errors %0d", words_q.size(), errors);
   endtask

   task automatic test_receive();
      make_words(3, 1'b0);
      pack_words();
      rx_lines = exp_lines;
      want_words = words_q;
      send_lines(1'b0);
      read_packet(1'b0);
      make_words(4, 1'b0);
      pack_words();
      resp_lines = exp_lines;
      resp_words = words_q;
      make_words(3, 1'b0);
      pack_words();
      rx_lines = exp_lines;
      rx_words = words_q;
      fork
         send_lines(1'b1);
         send_lines(1'b0);
      join
      want_words = resp_words;
      read_packet(1'b1);                              // Response goes first
      want_words = rx_words;
      read_packet(1'b0);
      $display("test_receive done, errors %0d", errors);
   endtask

   initial begin
      seed = 32'h6681_5877;
      cycles = 0;
      checks = 0;
      errors = 0;
      rst_n_i = 1'b0;
      ctl = 4'b0000;
      host_d = 16'h0000;
      tx_dst_rdy = 1'b1;
      ctrl_dst_rdy = 1'b1;
      rx_data = '0;
      rx_src_rdy = 1'b0;
      resp_data = '0;
      resp_src_rdy = 1'b0;
      repeat (3) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);
      test_reset();
      test_even_packet();
      test_odd_and_ctrl();
      test_back_pressure();
      test_receive();
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- build.f
hdl/gpif_pkg.sv
hdl/fifo_short.sv
hdl/gpif_wr.sv
hdl/fifo18_to_fifo36.sv
hdl/fifo36_demux.sv
hdl/fifo36_mux.sv
hdl/fifo36_to_fifo18.sv
hdl/gpif_rd.sv
hdl/gpif.sv
bench/gpif_checker.sv
bench/gpif_tb.sv

//--- Bender.yml
package:
  name: gpif

sources:
  - hdl/gpif_pkg.sv
  - hdl/fifo_short.sv
  - hdl/gpif_wr.sv
  - hdl/fifo18_to_fifo36.sv
  - hdl/fifo36_demux.sv
  - hdl/fifo36_mux.sv
  - hdl/fifo36_to_fifo18.sv
  - hdl/gpif_rd.sv
  - hdl/gpif.sv
  - target: simulation
    files:
      - bench/gpif_checker.sv
      - bench/gpif_tb.sv
